//--- logic/vec_coproc_top.sv
// vector co-processor top
// controller, issue, two pipe buffers, exec lanes and store unit
`default_nettype none

`include "vec_defs.svh"

module vec_coproc_top (
	input  wire logic                   clk_i,
	input  wire logic                   rstn_i,
	input  wire logic                   valid_i,
	input  wire vec_isa_pkg::vinstr_t   instr_i,
	input  wire logic [`VEC_ELEM_W-1:0] rs1_i,
	output logic                        pop_o,
	output logic                        valid_o,
	output logic                        idle_o,
	output logic                        mem_req_valid_o,
	output vec_pipe_pkg::mem_req_t      mem_req_o,
	input  wire logic                   cache_ready_i
);

	import vec_isa_pkg::*;
	import vec_pipe_pkg::*;

	// controller <-> issue
	logic                   push;
	vinstr_t                push_instr;
	logic [`VEC_ELEM_W-1:0] push_rs1;
	logic                   finished;
	logic                   ctrl_idle;

	// issue -> buffers -> consumers
	exec_req_t  exec_wdata;
	exec_req_t  exec_rdata;
	logic       exec_we;
	logic       exec_free;
	logic       exec_avail;
	logic       exec_take;
	store_req_t store_wdata;
	store_req_t store_rdata;
	logic       store_we;
	logic       store_free;
	logic       store_avail;
	logic       store_take;

	// completion paths back into issue
	logic [`VEC_LANES-1:0]  wb_en;
	logic [VREG_IDX_W-1:0]  wb_vd;
	vreg_t                  wb_data;
	logic                   store_done;

	assign idle_o = ctrl_idle & exec_free & store_free;

	vec_dispatch_ctrl u_ctrl (
		.clk_i      (clk_i),
		.rstn_i     (rstn_i),
		.valid_i    (valid_i),
		.instr_i    (instr_i),
		.rs1_i      (rs1_i),
		.finished_i (finished),
		.pop_o      (pop_o),
		.push_o     (push),
		.instr_o    (push_instr),
		.rs1_o      (push_rs1),
		.valid_o    (valid_o),
		.ctrl_idle_o(ctrl_idle)
	);

	vec_issue u_issue (
		.clk_i       (clk_i),
		.rstn_i      (rstn_i),
		.push_i      (push),
		.instr_i     (push_instr),
		.rs1_i       (push_rs1),
		.exec_req_o  (exec_wdata),
		.exec_we_o   (exec_we),
		.store_req_o (store_wdata),
		.store_we_o  (store_we),
		.wb_en_i     (wb_en),
		.wb_vd_i     (wb_vd),
		.wb_data_i   (wb_data),
		.store_done_i(store_done),
		.finished_o  (finished)
	);

	//////////////////////////////
	// pipe buffers
	//////////////////////////////
	vec_pipe_buffer #(.WIDTH($bits(exec_req_t))) exec_buf (
		.clk_i  (clk_i),
		.rstn_i (rstn_i),
		.wdata_i(exec_wdata),
		.we_i   (exec_we),
		.free_o (exec_free),
		.re_i   (exec_take),
		.rdata_o(exec_rdata),
		.avail_o(exec_avail)
	);

	vec_pipe_buffer #(.WIDTH($bits(store_req_t))) store_buf (
		.clk_i  (clk_i),
		.rstn_i (rstn_i),
		.wdata_i(store_wdata),
		.we_i   (store_we),
		.free_o (store_free),
		.re_i   (store_take),
		.rdata_o(store_rdata),
		.avail_o(store_avail)
	);

	vec_exec_lanes u_exec (
		.clk_i    (clk_i),
		.rstn_i   (rstn_i),
		.avail_i  (exec_avail),
		.req_i    (exec_rdata),
		.take_o   (exec_take),
		.wb_en_o  (wb_en),
		.wb_vd_o  (wb_vd),
		.wb_data_o(wb_data)
	);

	vec_store_unit u_store (
		.clk_i          (clk_i),
		.rstn_i         (rstn_i),
		.avail_i        (store_avail),
		.req_i          (store_rdata),
		.take_o         (store_take),
		.mem_req_valid_o(mem_req_valid_o),
		.mem_req_o      (mem_req_o),
		.cache_ready_i  (cache_ready_i),
		.store_done_o   (store_done)
	);

endmodule

`default_nettype wire

//--- logic/vec_defs.svh
// vector co-processor build constants
// lane count, register file size and datapath widths
`ifndef VEC_DEFS_SVH
`define VEC_DEFS_SVH

// simd lanes in the datapath
`define VEC_LANES 8

// architectural vector registers
`define VEC_REGS 32

// bits per lane element
`define VEC_ELEM_W 32

// byte address width of a store
`define VEC_ADDR_W 32

// vector length field, 0..8 legal, larger acts as 8
`define VEC_VL_W 4

`endif

//--- logic/vec_dispatch_ctrl.sv
// vector dispatch controller
// takes one instruction from the CPU, pushes it into the pipe
// and reports completion with a one-cycle valid pulse
`default_nettype none

`include "vec_defs.svh"

module vec_dispatch_ctrl (
	input  wire logic                   clk_i,
	input  wire logic                   rstn_i,
	input  wire logic                   valid_i,    // CPU has an instruction
	input  wire vec_isa_pkg::vinstr_t   instr_i,
	input  wire logic [`VEC_ELEM_W-1:0] rs1_i,      // scalar operand / address
	input  wire logic                   finished_i, // from issue
	output logic                        pop_o,      // CPU may drop valid_i
	output logic                        push_o,     // strobe into issue
	output vec_isa_pkg::vinstr_t        instr_o,
	output logic [`VEC_ELEM_W-1:0]      rs1_o,
	output logic                        valid_o,    // instruction retired
	output logic                        ctrl_idle_o
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_PUSH,
		S_BUSY,
		S_DONE
	} state_e;

	state_e state_q;

	always_ff @(posedge clk_i or negedge rstn_i) begin : dispatch_fsm
		if (!rstn_i) begin
			state_q <= S_IDLE;
			instr_o <= '0;
			rs1_o   <= '0;
			valid_o <= 1'b0;
		end else begin
			valid_o <= (state_q == S_DONE); // pulse lands one cycle after done
			case (state_q)
				S_IDLE: begin
					if (valid_i) begin
						instr_o <= instr_i; // latch, CPU side is released by pop
						rs1_o   <= rs1_i;
						state_q <= S_PUSH;
					end
				end
				S_PUSH: begin
					state_q <= S_BUSY; // issue accepts the push unconditionally
				end
				S_BUSY: begin
					if (finished_i) begin
						state_q <= S_DONE;
					end
				end
				S_DONE: begin
					state_q <= S_IDLE;
				end
				default: begin
					state_q <= S_IDLE;
				end
			endcase
		end
	end : dispatch_fsm

	assign pop_o       = (state_q == S_PUSH); // pop and push share the cycle
	assign push_o      = (state_q == S_PUSH);
	assign ctrl_idle_o = (state_q == S_IDLE);

	// completion is a single-cycle pulse
	a_valid_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i)
		valid_o |=> !valid_o);

	// finished only while an instruction is in flight
	a_finish_busy: assert property (@(posedge clk_i) disable iff (!rstn_i)
		finished_i |-> (state_q == S_BUSY));

endmodule

`default_nettype wire

//--- logic/vec_exec_lanes.sv
// vector integer execute lanes
// one 32-bit ALU per lane, result and lane enables registered
// into a one-cycle writeback to the register file
`default_nettype none

`include "vec_defs.svh"

module vec_exec_lanes (
	input  wire logic                               clk_i,
	input  wire logic                               rstn_i,
	input  wire logic                               avail_i, // exec buffer full
	input  wire vec_pipe_pkg::exec_req_t            req_i,
	output logic                                    take_o,
	output logic [`VEC_LANES-1:0]                   wb_en_o,
	output logic [vec_isa_pkg::VREG_IDX_W-1:0]      wb_vd_o,
	output vec_pipe_pkg::vreg_t                     wb_data_o
);

	import vec_isa_pkg::*;
	import vec_pipe_pkg::*;

	vreg_t alu_res;

	assign take_o = avail_i; // result register frees every cycle

	for (genvar l = 0; l < `VEC_LANES; l++) begin : g_lane
		logic [`VEC_ELEM_W-1:0] op_a;
		logic [`VEC_ELEM_W-1:0] op_b;
		logic [`VEC_ELEM_W-1:0] res;

		assign op_a = req_i.a[l];
		assign op_b = req_i.b[l];

		always_comb begin
			case (req_i.op)
				VADD_VV: res = op_a + op_b; // wraps mod 2^32
				VSUB_VV: res = op_a - op_b;
				VAND_VV: res = op_a & op_b;
				VOR_VV:  res = op_a | op_b;
				VXOR_VV: res = op_a ^ op_b;
				VADD_VI, VADD_VX: res = op_a + req_i.scalar;
				VMV_VX:  res = req_i.scalar; // broadcast
				default: res = '0; // stores never get here
			endcase
		end

		assign alu_res[l] = res;
	end : g_lane

	always_ff @(posedge clk_i or negedge rstn_i) begin : wb_reg
		if (!rstn_i) begin
			wb_en_o   <= '0;
			wb_vd_o   <= '0;
			wb_data_o <= '0;
		end else begin
			wb_en_o <= avail_i ? vl_mask(req_i.vl) : '0; // strobe, one cycle only
			if (avail_i) begin
				wb_vd_o   <= req_i.vd;
				wb_data_o <= alu_res;
			end
		end
	end : wb_reg

	// serialized dispatch gives back-to-back writebacks no room
	a_wb_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i)
		(|wb_en_o) |=> !(|wb_en_o));

endmodule

`default_nettype wire

//--- logic/vec_isa_pkg.sv
// vector ISA types
// instruction word and opcodes as the scalar CPU hands them over
`default_nettype none

`include "vec_defs.svh"

package vec_isa_pkg;

	localparam int VREG_IDX_W = $clog2(`VEC_REGS); // register index bits

	//////////////////////////////
	// opcodes
	//////////////////////////////
	typedef enum logic [3:0] {
		VADD_VV = 4'd0, // vd = vs2 + vs1
		VSUB_VV = 4'd1, // vd = vs2 - vs1
		VAND_VV = 4'd2,
		VOR_VV  = 4'd3,
		VXOR_VV = 4'd4,
		VADD_VI = 4'd5, // vd = vs2 + sext(imm5)
		VADD_VX = 4'd6, // vd = vs2 + rs1
		VMV_VX  = 4'd7, // broadcast rs1
		VSE     = 4'd8  // store register vd to rs1
	} vop_e;

	// source-1 field, register number or immediate depending on op
	typedef union packed {
		logic        [VREG_IDX_W-1:0] vreg; // vector source register
		logic signed [VREG_IDX_W-1:0] imm5; // signed immediate, VADD_VI only
	} vsrc1_u;

	typedef struct packed {
		vop_e                    op;  // operation
		logic [VREG_IDX_W-1:0]   vd;  // destination, or store source
		vsrc1_u                  vs1; // source 1 / immediate
		logic [VREG_IDX_W-1:0]   vs2; // source 2
		logic [`VEC_VL_W-1:0]    vl;  // active element count
	} vinstr_t;

endpackage

`default_nettype wire

//--- logic/vec_issue.sv
// vector issue stage
// architectural register file, operand read and op steering,
// lane-wise writeback and completion detection
`default_nettype none

`include "vec_defs.svh"

module vec_issue (
	input  wire logic                                   clk_i,
	input  wire logic                                   rstn_i,
	input  wire logic                                   push_i,  // new instruction
	input  wire vec_isa_pkg::vinstr_t                   instr_i,
	input  wire logic [`VEC_ELEM_W-1:0]                 rs1_i,
	output vec_pipe_pkg::exec_req_t                     exec_req_o,
	output logic                                        exec_we_o,
	output vec_pipe_pkg::store_req_t                    store_req_o,
	output logic                                        store_we_o,
	input  wire logic [`VEC_LANES-1:0]                  wb_en_i, // per-lane write
	input  wire logic [vec_isa_pkg::VREG_IDX_W-1:0]     wb_vd_i,
	input  wire vec_pipe_pkg::vreg_t                    wb_data_i,
	input  wire logic                                   store_done_i,
	output logic                                        finished_o
);

	import vec_isa_pkg::*;
	import vec_pipe_pkg::*;

	vreg_t                  rf_q [`VEC_REGS]; // architectural vector regs
	vreg_t                  src_a;
	vreg_t                  src_b;
	vreg_t                  src_st;
	logic [`VEC_ELEM_W-1:0] imm_ext;
	logic [`VEC_ELEM_W-1:0] scalar;
	logic                   is_store;
	logic                   zero_len;

	//////////////////////////////
	// decode and operand read
	//////////////////////////////
	assign is_store = (instr_i.op == VSE);
	assign zero_len = (instr_i.vl == '0); // nothing to compute, retire at once

	assign src_a  = rf_q[instr_i.vs2];
	assign src_b  = rf_q[instr_i.vs1.vreg];
	assign src_st = rf_q[instr_i.vd]; // store source sits in the vd field

	// imm5 sign extension
	assign imm_ext = {{(`VEC_ELEM_W-VREG_IDX_W){instr_i.vs1.imm5[VREG_IDX_W-1]}},
		instr_i.vs1.imm5};
	assign scalar  = (instr_i.op == VADD_VI) ? imm_ext : rs1_i;

	always_comb begin
		exec_req_o.op     = instr_i.op;
		exec_req_o.vd     = instr_i.vd;
		exec_req_o.vl     = instr_i.vl;
		exec_req_o.a      = src_a;
		exec_req_o.b      = src_b;
		exec_req_o.scalar = scalar;

		store_req_o.addr = rs1_i; // base address from the scalar side
		store_req_o.data = src_st;
		store_req_o.vl   = instr_i.vl;
	end

	// steer to one of the two paths
	assign exec_we_o  = push_i & ~is_store & ~zero_len;
	assign store_we_o = push_i & is_store;

	//////////////////////////////
	// writeback and finish
	//////////////////////////////
	always_ff @(posedge clk_i or negedge rstn_i) begin : rf_write
		if (!rstn_i) begin
			for (int r = 0; r < `VEC_REGS; r++) begin
				rf_q[r] <= '0;
			end
			finished_o <= 1'b0;
		end else begin
			for (int l = 0; l < `VEC_LANES; l++) begin
				if (wb_en_i[l]) begin
					rf_q[wb_vd_i][l] <= wb_data_i[l]; // disabled lanes keep old value
				end
			end
			// rf already updated when finished is seen
			finished_o <= (|wb_en_i) | store_done_i | (push_i & ~is_store & zero_len);
		end
	end : rf_write

endmodule

`default_nettype wire

//--- logic/vec_pipe_buffer.sv
// one-entry pipeline buffer
// registered payload with a full flag, read side is asynchronous
`default_nettype none

module vec_pipe_buffer #(
	parameter int WIDTH = 32 // payload bits
) (
	input  wire logic             clk_i,
	input  wire logic             rstn_i,
	input  wire logic [WIDTH-1:0] wdata_i,
	input  wire logic             we_i,    // write strobe
	output logic                  free_o,  // entry empty
	input  wire logic             re_i,    // consumer take
	output logic      [WIDTH-1:0] rdata_o,
	output logic                  avail_o  // entry holds data
);

	logic [WIDTH-1:0] data_q;
	logic             full_q;

	always_ff @(posedge clk_i or negedge rstn_i) begin
		if (!rstn_i) begin
			data_q <= '0;
			full_q <= 1'b0;
		end else begin
			if (we_i) begin
				data_q <= wdata_i;
			end
			full_q <= we_i | (full_q & ~re_i); // take empties in the same cycle
		end
	end

	assign free_o  = ~full_q;
	assign avail_o = full_q; // one cycle after the write
	assign rdata_o = data_q;

	// producer must wait for free_o
	a_no_overwrite: assert property (@(posedge clk_i) disable iff (!rstn_i)
		we_i |-> !full_q);

endmodule

`default_nettype wire

//--- logic/vec_pipe_pkg.sv
// vector pipeline types
// stage-to-stage requests, the cache request and lane masking
`default_nettype none

`include "vec_defs.svh"

package vec_pipe_pkg;

	typedef logic [`VEC_LANES-1:0][`VEC_ELEM_W-1:0] vreg_t; // one element per lane

	// issue -> exec lanes
	typedef struct packed {
		vec_isa_pkg::vop_e                    op;
		logic [vec_isa_pkg::VREG_IDX_W-1:0]   vd;
		logic [`VEC_VL_W-1:0]                 vl;
		vreg_t                                a;      // vs2 contents
		vreg_t                                b;      // vs1 contents
		logic [`VEC_ELEM_W-1:0]               scalar; // rs1 or extended imm5
	} exec_req_t;

	// issue -> store unit
	typedef struct packed {
		logic [`VEC_ADDR_W-1:0] addr;
		vreg_t                  data;
		logic [`VEC_VL_W-1:0]   vl;
	} store_req_t;

	// cache request port
	typedef struct packed {
		logic [`VEC_ADDR_W-1:0] addr;
		vreg_t                  data;
		logic [`VEC_LANES-1:0]  lane_mask; // bytes of these lanes are written
	} mem_req_t;

	// lanes below vl are active
	function automatic logic [`VEC_LANES-1:0] vl_mask(input logic [`VEC_VL_W-1:0] vl);
		logic [`VEC_LANES-1:0] m;
		for (int i = 0; i < `VEC_LANES; i++) begin
			m[i] = (int'(vl) > i); // vl above lane count saturates naturally
		end
		return m;
	endfunction

endpackage

`default_nettype wire

//--- logic/vec_store_unit.sv
// vector store unit
// turns a store into a cache request and holds it until accepted
`default_nettype none

`include "vec_defs.svh"

module vec_store_unit (
	input  wire logic                     clk_i,
	input  wire logic                     rstn_i,
	input  wire logic                     avail_i,        // store buffer full
	input  wire vec_pipe_pkg::store_req_t req_i,
	output logic                          take_o,
	output logic                          mem_req_valid_o,
	output vec_pipe_pkg::mem_req_t        mem_req_o,
	input  wire logic                     cache_ready_i,
	output logic                          store_done_o    // one cycle after accept
);

	import vec_pipe_pkg::*;

	assign take_o = avail_i & ~mem_req_valid_o; // only when nothing pending

	always_ff @(posedge clk_i or negedge rstn_i) begin : req_hold
		if (!rstn_i) begin
			mem_req_valid_o <= 1'b0;
			mem_req_o       <= '0;
			store_done_o    <= 1'b0;
		end else begin
			store_done_o <= mem_req_valid_o & cache_ready_i; // handshake fired
			if (take_o) begin
				mem_req_valid_o     <= 1'b1;
				mem_req_o.addr      <= req_i.addr;
				mem_req_o.data      <= req_i.data; // whole register, mask selects
				mem_req_o.lane_mask <= vl_mask(req_i.vl);
			end else if (cache_ready_i) begin
				mem_req_valid_o <= 1'b0; // accepted, drop valid
			end
		end
	end : req_hold

	// request frozen under back-pressure
	a_req_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
		(mem_req_valid_o && !cache_ready_i) |=> (mem_req_valid_o && $stable(mem_req_o)));

endmodule

`default_nettype wire

//--- project.f
+incdir+logic
logic/vec_isa_pkg.sv
logic/vec_pipe_pkg.sv
logic/vec_dispatch_ctrl.sv
logic/vec_pipe_buffer.sv
logic/vec_issue.sv
logic/vec_exec_lanes.sv
logic/vec_store_unit.sv
logic/vec_coproc_top.sv
verification/tb_vec_coproc.sv

//--- verification/tb_vec_coproc.sv
// testbench for the vector co-processor
// issues instructions like a scalar CPU, keeps a register-file model
// and checks stores, handshakes and timing with concurrent assertions
`default_nettype none

`include "vec_defs.svh"

module tb_vec_coproc;

	timeunit 1ns;
	timeprecision 1ps;

	import vec_isa_pkg::*;
	import vec_pipe_pkg::*;

	localparam int N_INSTR     = 3 + 6 + 19 + 10 + 6 + 6; // instructions over all tests
	localparam int CYCLE_LIMIT = 40 * N_INSTR + 8;         // plus the reset

	logic                   clk_i = 1'b0;
	logic                   rstn_i;
	logic                   valid_i;
	vinstr_t                instr_i;
	logic [`VEC_ELEM_W-1:0] rs1_i;
	logic                   cache_ready_i = 1'b1;
	logic                   pop_o;
	logic                   valid_o;
	logic                   idle_o;
	logic                   mem_req_valid_o;
	mem_req_t               mem_req_o;

	vreg_t                  model_rf [`VEC_REGS]; // expected register contents
	vreg_t                  exp_data;             // expected store payload
	logic [`VEC_LANES-1:0]  exp_mask;
	logic [`VEC_ADDR_W-1:0] exp_addr;
	logic                   cur_is_store = 1'b0;  // instruction in flight is a VSE
	logic                   stall_en = 1'b0;      // random back-pressure on
	logic [31:0]            stim_lfsr = 32'h9398;
	logic [31:0]            stall_lfsr = 32'h9398;
	int                     stall_len = 0;
	int                     outstanding;          // pops not yet answered by valid_o
	int                     acc_cnt;              // cache accepts since last valid_o
	int                     cycle_cnt = 0;
	int                     err_cnt = 0;
	int                     tests_run = 0;
	int                     test_err0 = 0;
	string                  test_name = "none";
	vop_e                   vv_ops [5] = '{VADD_VV, VSUB_VV, VAND_VV, VOR_VV, VXOR_VV};
	logic [4:0]             imm_set [4] = '{5'h10, 5'h1f, 5'h05, 5'h0f}; // -16 -1 5 15
	logic [4:0]             st_regs [6] = '{5'd4, 5'd5, 5'd10, 5'd11, 5'd12, 5'd13};

	always #50 clk_i = ~clk_i; // 100 ns period

	vec_coproc_top UUT (
		.clk_i          (clk_i),
		.rstn_i         (rstn_i),
		.valid_i        (valid_i),
		.instr_i        (instr_i),
		.rs1_i          (rs1_i),
		.pop_o          (pop_o),
		.valid_o        (valid_o),
		.idle_o         (idle_o),
		.mem_req_valid_o(mem_req_valid_o),
		.mem_req_o      (mem_req_o),
		.cache_ready_i  (cache_ready_i)
	);

	//////////////////////////////
	// random source and models
	//////////////////////////////
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 32'hA300_0000; // x^32 + x^30 + x^26 + x^25 + 1
		end
		return n;
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], stim_lfsr[0]}; // one step per bit
			stim_lfsr = lfsr_next(stim_lfsr);
		end
	endtask

	function automatic logic [`VEC_LANES-1:0] lanes_below(input logic [`VEC_VL_W-1:0] vl);
		int                  n;
		logic [`VEC_LANES:0] w;
		n = (vl > `VEC_LANES) ? `VEC_LANES : vl; // long lengths saturate
		w = ({{`VEC_LANES{1'b0}}, 1'b1} << n) - 1'b1;
		return w[`VEC_LANES-1:0];
	endfunction

	task automatic apply_model(input vinstr_t ins, input logic [31:0] rs1);
		vreg_t                 res;
		logic [31:0]           imm;
		logic [`VEC_LANES-1:0] en;
		res = model_rf[ins.vd];
		imm = {{27{ins.vs1.imm5[4]}}, ins.vs1.imm5};
		en  = lanes_below(ins.vl);
		for (int l = 0; l < `VEC_LANES; l++) begin
			if (en[l] && ins.op != VSE) begin
				case (ins.op)
					VADD_VV: res[l] = model_rf[ins.vs2][l] + model_rf[ins.vs1.vreg][l];
					VSUB_VV: res[l] = model_rf[ins.vs2][l] - model_rf[ins.vs1.vreg][l];
					VAND_VV: res[l] = model_rf[ins.vs2][l] & model_rf[ins.vs1.vreg][l];
					VOR_VV:  res[l] = model_rf[ins.vs2][l] | model_rf[ins.vs1.vreg][l];
					VXOR_VV: res[l] = model_rf[ins.vs2][l] ^ model_rf[ins.vs1.vreg][l];
					VADD_VI: res[l] = model_rf[ins.vs2][l] + imm;
					VADD_VX: res[l] = model_rf[ins.vs2][l] + rs1;
					VMV_VX:  res[l] = rs1;
					default: res[l] = res[l];
				endcase
			end
		end
		model_rf[ins.vd] = res; // lanes at or above vl untouched
	endtask

	// called right after a clock edge, returns on the edge that sees valid_o
	task automatic run_instr(input vop_e op, input logic [4:0] vd, input logic [4:0] vs1,
		input logic [4:0] vs2, input logic [3:0] vl, input logic [31:0] rs1);
		vinstr_t ins;
		ins.op       = op;
		ins.vd       = vd;
		ins.vs2      = vs2;
		ins.vl       = vl;
		ins.vs1.vreg = vs1; // imm5 view shares these bits
		exp_data     <= model_rf[vd];
		exp_mask     <= lanes_below(vl);
		exp_addr     <= rs1;
		cur_is_store <= (op == VSE);
		valid_i      <= 1'b1;
		instr_i      <= ins;
		rs1_i        <= rs1;
		do @(posedge clk_i); while (!pop_o); // hold until popped
		valid_i <= 1'b0;
		do @(posedge clk_i); while (!valid_o);
		apply_model(ins, rs1);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_err0 = err_cnt;
		tests_run++;
	endtask

	task automatic finish_test();
		@(posedge clk_i); // let checks of the last edge report
		if (err_cnt == test_err0) begin
			$display("test %s: ok", test_name);
		end else begin
			$display("test %s: %0d check(s) failed", test_name, err_cnt - test_err0);
		end
	endtask

	//////////////////////////////
	// back-pressure and watchdog
	//////////////////////////////
	always @(posedge clk_i) begin : ready_gen
		if (!stall_en) begin
			cache_ready_i <= 1'b1;
			stall_len = 0;
		end else if (stall_len != 0) begin
			cache_ready_i <= 1'b0; // low stretch
			stall_len = stall_len - 1;
		end else begin
			cache_ready_i <= 1'b1;
			for (int i = 0; i < 3; i++) begin
				stall_len = stall_len * 2 + stall_lfsr[0]; // next stretch 0..7
				stall_lfsr = lfsr_next(stall_lfsr);
			end
		end
	end : ready_gen

	always @(posedge clk_i) begin : watchdog
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("timeout: no completion within %0d cycles in test %s", CYCLE_LIMIT,
				test_name);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end : watchdog

	always @(posedge clk_i or negedge rstn_i) begin : track
		if (!rstn_i) begin
			outstanding <= 0;
			acc_cnt     <= 0;
		end else begin
			outstanding <= outstanding + int'(pop_o) - int'(valid_o);
			if (valid_o) begin
				acc_cnt <= 0;
			end else if (mem_req_valid_o && cache_ready_i) begin
				acc_cnt <= acc_cnt + 1; // handshake fired
			end
		end
	end : track

	//////////////////////////////
	// checks
	//////////////////////////////
	// bit order valid_o pop_o mem_req_valid_o idle_o
	a_reset_state: assert property (@(posedge clk_i) $rose(rstn_i) |->
		(!valid_o && !pop_o && !mem_req_valid_o && idle_o))
		else begin
			$display("FAILED %s: reset outputs expected 0001, actual %b%b%b%b", test_name,
				$sampled(valid_o), $sampled(pop_o), $sampled(mem_req_valid_o),
				$sampled(idle_o));
			err_cnt++;
		end

	a_store_data: assert property (@(posedge clk_i) disable iff (!rstn_i)
		(mem_req_valid_o && cache_ready_i) |-> (mem_req_o.data == exp_data))
		else begin
			$display("FAILED %s: store data expected %h, actual %h", test_name,
				$sampled(exp_data), $sampled(mem_req_o.data));
			err_cnt++;
		end

	a_store_mask: assert property (@(posedge clk_i) disable iff (!rstn_i)
		(mem_req_valid_o && cache_ready_i) |-> (mem_req_o.lane_mask == exp_mask))
		else begin
			$display("FAILED %s: lane_mask expected %h, actual %h", test_name,
				$sampled(exp_mask), $sampled(mem_req_o.lane_mask));
			err_cnt++;
		end

	a_store_addr: assert property (@(posedge clk_i) disable iff (!rstn_i)
		(mem_req_valid_o && cache_ready_i) |-> (mem_req_o.addr == exp_addr))
		else begin
			$display("FAILED %s: addr expected %h, actual %h", test_name,
				$sampled(exp_addr), $sampled(mem_req_o.addr));
			err_cnt++;
		end

	a_req_held: assert property (@(posedge clk_i) disable iff (!rstn_i)
		(mem_req_valid_o && !cache_ready_i) |=> (mem_req_valid_o && $stable(mem_req_o)))
		else begin
			$display("cache request changed or dropped while stalled in test %s", test_name);
			err_cnt++;
		end

	a_one_accept: assert property (@(posedge clk_i) disable iff (!rstn_i)
		valid_o |-> (acc_cnt == (cur_is_store ? 1 : 0)))
		else begin
			$display("FAILED %s: store accepts expected %0d, actual %0d", test_name,
				cur_is_store ? 1 : 0, $sampled(acc_cnt));
			err_cnt++;
		end

	a_pop_held: assert property (@(posedge clk_i) disable iff (!rstn_i)
		pop_o |-> (valid_i && $past(valid_i)))
		else begin
			$display("pop_o came without a held valid_i in test %s", test_name);
			err_cnt++;
		end

	a_pop_single: assert property (@(posedge clk_i) disable iff (!rstn_i)
		pop_o |-> (outstanding == 0))
		else begin
			$display("pop_o came before the previous instruction completed in test %s",
				test_name);
			err_cnt++;
		end

	a_done_single: assert property (@(posedge clk_i) disable iff (!rstn_i)
		valid_o |-> (outstanding == 1))
		else begin
			$display("valid_o came with no instruction outstanding in test %s", test_name);
			err_cnt++;
		end

	a_idle_empty: assert property (@(posedge clk_i) disable iff (!rstn_i)
		(outstanding == 0 && !valid_i) |-> idle_o)
		else begin
			$display("FAILED %s: idle_o expected 1, actual %b", test_name,
				$sampled(idle_o));
			err_cnt++;
		end

	a_done_latency: assert property (@(posedge clk_i) disable iff (!rstn_i)
		UUT.finished |-> ##2 valid_o)
		else begin
			$display("valid_o did not follow finished by two cycles in test %s", test_name);
			err_cnt++;
		end

	//////////////////////////////
	// stimulus
	//////////////////////////////
	initial begin : stimulus
		logic [31:0] r;
		logic [31:0] s;
		logic [31:0] v;
		rstn_i  = 1'b0;
		valid_i = 1'b0;
		instr_i = '0;
		rs1_i   = '0;
		for (int i = 0; i < `VEC_REGS; i++) begin
			model_rf[i] = '0; // registers clear after reset
		end

		start_test("reset");
		repeat (8) @(posedge clk_i);
		rstn_i <= 1'b1;
		@(posedge clk_i);
		run_instr(VSE, 5'd0, 5'd0, 5'd0, 4'd8, 32'h0000_1000);
		run_instr(VSE, 5'd31, 5'd0, 5'd0, 4'd8, 32'h0000_2000);
		rand_bits(5, r);
		rand_bits(32, s);
		run_instr(VSE, r[4:0], 5'd0, 5'd0, 4'd8, s);
		finish_test();

		start_test("broadcast");
		for (int k = 1; k <= 3; k++) begin
			rand_bits(32, s);
			rand_bits(4, v); // 9..15 acts as 8
			rand_bits(32, r);
			run_instr(VMV_VX, 5'(k), 5'd0, 5'd0, v[3:0], s);
			run_instr(VSE, 5'(k), 5'd0, 5'd0, v[3:0], r);
		end
		finish_test();

		start_test("vector_vector");
		for (int k = 0; k < 4; k++) begin
			rand_bits(32, s);
			rand_bits(4, v);
			run_instr(VMV_VX, 5'(4 + k % 2), 5'd0, 5'd0, (k < 2) ? 4'd8 : v[3:0], s);
		end
		for (int k = 0; k < 5; k++) begin
			rand_bits(32, s);
			run_instr(VMV_VX, 5'(10 + k), 5'd0, 5'd0, 4'd8, s); // old lane values
			rand_bits(4, v);
			run_instr(vv_ops[k], 5'(10 + k), 5'd5, 5'd4, v[3:0], 32'h0);
			rand_bits(32, r);
			run_instr(VSE, 5'(10 + k), 5'd0, 5'd0, 4'd8, r);
		end
		finish_test();

		start_test("imm_scalar");
		for (int k = 0; k < 4; k++) begin
			rand_bits(4, v);
			run_instr(VADD_VI, 5'(20 + k), imm_set[k], 5'd4, v[3:0], 32'h0);
			rand_bits(32, r);
			run_instr(VSE, 5'(20 + k), 5'd0, 5'd0, 4'd8, r);
		end
		rand_bits(4, v);
		rand_bits(32, s);
		run_instr(VADD_VX, 5'd24, 5'd0, 5'd5, v[3:0], s);
		rand_bits(32, r);
		run_instr(VSE, 5'd24, 5'd0, 5'd0, 4'd8, r);
		finish_test();

		start_test("back_pressure");
		stall_en <= 1'b1;
		for (int k = 0; k < 6; k++) begin
			rand_bits(4, v);
			rand_bits(32, r);
			run_instr(VSE, st_regs[k], 5'd0, 5'd0, v[3:0], r);
		end
		stall_en <= 1'b0;
		finish_test();

		start_test("handshake");
		for (int k = 0; k < 3; k++) begin
			rand_bits(2, v);
			repeat (v[1:0]) @(posedge clk_i); // idle gap, may be zero
			rand_bits(32, s);
			rand_bits(4, v);
			run_instr(VMV_VX, 5'(26 + k), 5'd0, 5'd0, v[3:0], s);
			rand_bits(32, r);
			run_instr(VSE, 5'(26 + k), 5'd0, 5'd0, 4'd8, r); // back to back
		end
		finish_test();

		repeat (4) @(posedge clk_i);
		$display("tests run: %0d, checks failed: %0d", tests_run, err_cnt);
		if (err_cnt == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end : stimulus

endmodule

`default_nettype wire
